//--- logic/mipsPkg.sv
package mipsPkg;

    // primary opcodes, standard MIPS encodings
    typedef enum logic [5:0] {
        opR    = 6'h00,
        opJ    = 6'h02,
        opJal  = 6'h03,
        opBeq  = 6'h04,
        opBne  = 6'h05,
        opAddi = 6'h08,
        opOri  = 6'h0d,
        opLui  = 6'h0f,
        opLw   = 6'h23,
        opSw   = 6'h2b
    } opcodeE;

    // R-type function field
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sMemAddr,
        sMemRead,
        sMemReadBack,
        sMemWrite,
        sExecR,
        sRWriteBack,
        sExecI,
        sIWriteBack,
        sBranch,
        sJump,
        sJal
    } cpuStateE;

    // what the controller asks of the ALU
    typedef enum logic [1:0] {
        aluAdd   = 2'd0,
        aluSub   = 2'd1,
        aluFunct = 2'd2,
        aluImm   = 2'd3
    } aluOpE;

    // what the ALU actually computes
    typedef enum logic [2:0] {
        fnSelAdd,
        fnSelSub,
        fnSelAnd,
        fnSelOr,
        fnSelSlt,
        fnSelLui
    } aluFnE;

    // ALU operand B select
    localparam logic [1:0] srcBReg    = 2'd0;
    localparam logic [1:0] srcBFour   = 2'd1;
    localparam logic [1:0] srcBImm    = 2'd2;
    localparam logic [1:0] srcBBranch = 2'd3;

    // next-PC select
    localparam logic [1:0] pcSrcAlu    = 2'd0;
    localparam logic [1:0] pcSrcAluOut = 2'd1;
    localparam logic [1:0] pcSrcJump   = 2'd2;

    // register write-back data and destination
    localparam logic [1:0] wbAluOut = 2'd0;
    localparam logic [1:0] wbMdr    = 2'd1;
    localparam logic [1:0] wbLink   = 2'd2;
    localparam logic [1:0] dstRt    = 2'd0;
    localparam logic [1:0] dstRd    = 2'd1;
    localparam logic [1:0] dstRa    = 2'd2;

    typedef struct packed {
        logic       pcWrite;
        // bit 0 branch on zero, bit 1 branch on not zero
        logic [1:0] pcWriteCond;
        logic       iorD;
        logic       memRead;
        logic       memWrite;
        logic       irWrite;
        logic [1:0] memToReg;
        logic [1:0] regDstSel;
        logic       regWrite;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] pcSource;
        aluOpE      aluOp;
    } controlS;

    // one completed instruction
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  regNum;
        logic [31:0] regData;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } retireS;

endpackage

//--- logic/alu.sv
`timescale 1ns/10ps

module alu import mipsPkg::*; (
    input  aluOpE       aluOp,
    input  opcodeE      opcode,
    input  functE       funct,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero
);

    aluFnE fnSel;

    // class from the controller to an actual operation
    always_comb begin
        fnSel = fnSelAdd;
        case (aluOp)
            aluSub: fnSel = fnSelSub;
            aluFunct: begin
                case (funct)
                    fnSub:   fnSel = fnSelSub;
                    fnAnd:   fnSel = fnSelAnd;
                    fnOr:    fnSel = fnSelOr;
                    fnSlt:   fnSel = fnSelSlt;
                    default: fnSel = fnSelAdd;
                endcase
            end
            aluImm: begin
                case (opcode)
                    opOri:   fnSel = fnSelOr;
                    opLui:   fnSel = fnSelLui;
                    default: fnSel = fnSelAdd;
                endcase
            end
            default: fnSel = fnSelAdd;
        endcase
    end

    always_comb begin
        case (fnSel)
            fnSelSub: result = a - b;
            fnSelAnd: result = a & b;
            fnSelOr:  result = a | b;
            // signed compare
            fnSelSlt: result = {31'b0, $signed(a) < $signed(b)};
            fnSelLui: result = {b[15:0], 16'b0};
            default:  result = a + b;
        endcase
    end

    assign zero = (result == 32'b0);

endmodule

//--- logic/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  readReg1,
    input  logic [4:0]  readReg2,
    input  logic [4:0]  writeReg,
    input  logic        regWrite,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    // writes to $zero are dropped
    always_ff @(posedge clk) begin
        if (regWrite && (writeReg != 5'd0)) begin
            regs[writeReg] <= writeData;
        end
    end

    // register 0 always reads zero
    assign readData1 = (readReg1 == 5'd0) ? 32'b0 : regs[readReg1];
    assign readData2 = (readReg2 == 5'd0) ? 32'b0 : regs[readReg2];

endmodule

//--- logic/unifiedMemory.sv
`timescale 1ns/10ps

module unifiedMemory #(
    parameter int unsigned memWords = 256
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] addr,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [31:0] writeData,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic [31:0] readData
);

    localparam int idxBits = $clog2(memWords);

    logic [31:0]        mem [memWords];
    logic [idxBits-1:0] cpuIdx;
    logic [idxBits-1:0] loadIdx;

    // byte address to word index, wrapping around the array
    assign cpuIdx  = idxBits'(addr[31:2] % memWords);
    assign loadIdx = idxBits'(loadAddr[31:2] % memWords);

    // preload only while held in reset, CPU writes only after
    always_ff @(posedge clk) begin
        if (!rstN) begin
            if (loadEn) begin
                mem[loadIdx] <= loadData;
            end
        end else if (memWrite) begin
            mem[cpuIdx] <= writeData;
        end
    end

    assign readData = memRead ? mem[cpuIdx] : 32'b0;

endmodule

//--- logic/multiCycleControl.sv
`timescale 1ns/10ps

module multiCycleControl import mipsPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  opcodeE   opcode,
    input  functE    funct,
    output controlS  ctrl,
    output cpuStateE state
);

    cpuStateE nextState;
    logic     rTypeKnown;

    // unsupported R-type functions fall through as a no-op
    always_comb begin
        case (funct)
            fnAdd, fnSub, fnAnd, fnOr, fnSlt: rTypeKnown = 1'b1;
            default:                          rTypeKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = sFetch;
        case (state)
            sFetch: nextState = sDecode;
            sDecode: begin
                case (opcode)
                    opR:                 nextState = rTypeKnown ? sExecR : sBranch;
                    opAddi, opOri, opLui: nextState = sExecI;
                    opLw, opSw:          nextState = sMemAddr;
                    opBeq, opBne:        nextState = sBranch;
                    opJ:                 nextState = sJump;
                    opJal:               nextState = sJal;
                    // unknown opcode, three cycles doing nothing
                    default:             nextState = sBranch;
                endcase
            end
            sMemAddr: nextState = (opcode == opLw) ? sMemRead : sMemWrite;
            sMemRead: nextState = sMemReadBack;
            sExecR:   nextState = sRWriteBack;
            sExecI:   nextState = sIWriteBack;
            default:  nextState = sFetch;
        endcase
    end

    // Moore outputs, one control word per state
    always_comb begin
        ctrl = '0;
        case (state)
            sFetch: begin
                ctrl.memRead  = 1'b1;
                ctrl.irWrite  = 1'b1;
                ctrl.aluSrcB  = srcBFour;
                ctrl.pcSource = pcSrcAlu;
                ctrl.pcWrite  = 1'b1;
            end
            // branch target into ALUOut ahead of time
            sDecode: ctrl.aluSrcB = srcBBranch;
            sMemAddr: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = srcBImm;
            end
            sMemRead: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = 1'b1;
            end
            sMemReadBack: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = wbMdr;
                ctrl.regDstSel = dstRt;
            end
            sMemWrite: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = 1'b1;
            end
            sExecR: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = srcBReg;
                ctrl.aluOp   = aluFunct;
            end
            sRWriteBack: begin
                ctrl.regWrite  = 1'b1;
                ctrl.regDstSel = dstRd;
                ctrl.memToReg  = wbAluOut;
            end
            sExecI: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = srcBImm;
                ctrl.aluOp   = aluImm;
            end
            sIWriteBack: begin
                ctrl.regWrite  = 1'b1;
                ctrl.regDstSel = dstRt;
                ctrl.memToReg  = wbAluOut;
            end
            sBranch: begin
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = srcBReg;
                ctrl.aluOp    = aluSub;
                ctrl.pcSource = pcSrcAluOut;
                if (opcode == opBeq) begin
                    ctrl.pcWriteCond = 2'b01;
                end else if (opcode == opBne) begin
                    ctrl.pcWriteCond = 2'b10;
                end
            end
            sJump: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcSrcJump;
            end
            sJal: begin
                ctrl.pcWrite   = 1'b1;
                ctrl.pcSource  = pcSrcJump;
                ctrl.regWrite  = 1'b1;
                ctrl.regDstSel = dstRa;
                ctrl.memToReg  = wbLink;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/multiCycleCpu.sv
`timescale 1ns/10ps

module multiCycleCpu import mipsPkg::*; #(
    parameter int unsigned memWords = 256,
    parameter logic [31:0] resetPc  = 32'h0
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] memReadData,
    input  logic [31:0] regReadData1,
    input  logic [31:0] regReadData2,
    output logic [31:0] memAddr,
    output logic        memRead,
    output logic        memWrite,
    output logic [31:0] memWriteData,
    output logic [4:0]  readReg1,
    output logic [4:0]  readReg2,
    output logic [4:0]  writeReg,
    output logic        regWrite,
    output logic [31:0] regWriteData,
    output retireS      retire
);

    controlS     ctrl;
    cpuStateE    state;
    opcodeE      opcode;
    functE       funct;
    logic [31:0] pcQ, irQ, mdrQ, aQ, bQ, aluOutQ;
    // address of the instruction now in IR
    logic [31:0] instrPcQ;
    logic [31:0] signImm, immOperand, jumpTarget;
    logic [31:0] srcA, srcB, aluResult, nextPc, dataWordAddr;
    logic        aluZero, pcEn;

    assign opcode = opcodeE'(irQ[31:26]);
    assign funct  = functE'(irQ[5:0]);

    multiCycleControl control (
        .clk    (clk),
        .rstN   (rstN),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl),
        .state  (state)
    );

    // ori zero-extends, everything else sign-extends
    assign signImm    = {{16{irQ[15]}}, irQ[15:0]};
    assign immOperand = (opcode == opOri) ? {16'b0, irQ[15:0]} : signImm;
    assign jumpTarget = {pcQ[31:28], irQ[25:0], 2'b00};

    assign srcA = ctrl.aluSrcA ? aQ : pcQ;
    always_comb begin
        case (ctrl.aluSrcB)
            srcBReg:  srcB = bQ;
            srcBFour: srcB = 32'd4;
            srcBImm:  srcB = immOperand;
            default:  srcB = signImm << 2;
        endcase
    end

    alu aluUnit (
        .aluOp  (ctrl.aluOp),
        .opcode (opcode),
        .funct  (funct),
        .a      (srcA),
        .b      (srcB),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign pcEn = ctrl.pcWrite | (ctrl.pcWriteCond[0] & aluZero) |
                  (ctrl.pcWriteCond[1] & ~aluZero);

    always_comb begin
        case (ctrl.pcSource)
            pcSrcAluOut: nextPc = aluOutQ;
            pcSrcJump:   nextPc = jumpTarget;
            default:     nextPc = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcQ <= resetPc;
        end else if (pcEn) begin
            pcQ <= nextPc;
        end
    end

    // datapath holding registers
    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            irQ      <= memReadData;
            instrPcQ <= pcQ;
        end
        mdrQ    <= memReadData;
        aQ      <= regReadData1;
        bQ      <= regReadData2;
        aluOutQ <= aluResult;
    end

    assign memAddr      = ctrl.iorD ? aluOutQ : pcQ;
    assign memRead      = ctrl.memRead;
    assign memWrite     = ctrl.memWrite;
    assign memWriteData = bQ;

    assign readReg1 = irQ[25:21];
    assign readReg2 = irQ[20:16];
    assign regWrite = ctrl.regWrite;

    always_comb begin
        case (ctrl.regDstSel)
            dstRd:   writeReg = irQ[15:11];
            dstRa:   writeReg = 5'd31;
            default: writeReg = irQ[20:16];
        endcase
    end

    // pcQ already holds PC+4 once fetch is done, so it is the link value
    always_comb begin
        case (ctrl.memToReg)
            wbMdr:   regWriteData = mdrQ;
            wbLink:  regWriteData = pcQ;
            default: regWriteData = aluOutQ;
        endcase
    end

    // same wrap as the memory array
    assign dataWordAddr = 32'(aluOutQ[31:2] % memWords);

    // report in the final state of each instruction class
    always_comb begin
        retire.valid    = state inside {sBranch, sJump, sJal, sRWriteBack,
                                        sIWriteBack, sMemWrite, sMemReadBack};
        retire.pc       = instrPcQ;
        retire.regWrite = ctrl.regWrite;
        retire.regNum   = writeReg;
        retire.regData  = regWriteData;
        retire.memWrite = ctrl.memWrite;
        retire.memAddr  = ctrl.memWrite ? (dataWordAddr << 2) : 32'b0;
        retire.memData  = ctrl.memWrite ? bQ : 32'b0;
    end

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/10ps

module cpuTop import mipsPkg::*; #(
    parameter int unsigned memWords = 256,
    parameter logic [31:0] resetPc  = 32'h0
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output retireS      retire
);

    logic [31:0] memAddr, memReadData, memWriteData;
    logic        memRead, memWrite;
    logic [4:0]  readReg1, readReg2, writeReg;
    logic [31:0] regReadData1, regReadData2, regWriteData;
    logic        regWrite;

    multiCycleCpu #(
        .memWords (memWords),
        .resetPc  (resetPc)
    ) cpu (
        .clk          (clk),
        .rstN         (rstN),
        .memReadData  (memReadData),
        .regReadData1 (regReadData1),
        .regReadData2 (regReadData2),
        .memAddr      (memAddr),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memWriteData (memWriteData),
        .readReg1     (readReg1),
        .readReg2     (readReg2),
        .writeReg     (writeReg),
        .regWrite     (regWrite),
        .regWriteData (regWriteData),
        .retire       (retire)
    );

    regFile regs (
        .clk       (clk),
        .readReg1  (readReg1),
        .readReg2  (readReg2),
        .writeReg  (writeReg),
        .regWrite  (regWrite),
        .writeData (regWriteData),
        .readData1 (regReadData1),
        .readData2 (regReadData2)
    );

    unifiedMemory #(
        .memWords (memWords)
    ) mem (
        .clk       (clk),
        .rstN      (rstN),
        .addr      (memAddr),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .writeData (memWriteData),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .readData  (memReadData)
    );

endmodule

//--- sim/cpu_assertions.sv
`timescale 1ns/10ps

module cpuAssertions import mipsPkg::*; (
    input logic     clk,
    input logic     rstN,
    input controlS  ctrl,
    input cpuStateE state,
    input retireS   retire
);

    int sinceFetch;
    int failures = 0;

    // cycles spent outside sFetch since the last fetch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sinceFetch <= 0;
        end else if (state == sFetch) begin
            sinceFetch <= 0;
        end else begin
            sinceFetch <= sinceFetch + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !(ctrl.memWrite && ctrl.regWrite))
        else begin
            $error("memWrite and regWrite high in the same cycle");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rstN) ctrl.irWrite |-> state == sFetch)
        else begin
            $error("irWrite high outside sFetch");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rstN) retire.valid |=> state == sFetch)
        else begin
            $error("retire valid not followed by sFetch");
            failures++;
        end

    // lw is the longest class at five cycles from fetch to fetch
    assert property (@(posedge clk) disable iff (!rstN) (sinceFetch < 4) || (state == sFetch))
        else begin
            $error("state machine did not return to sFetch within 5 cycles");
            failures++;
        end

endmodule

bind multiCycleCpu cpuAssertions stateChecks (
    .clk    (clk),
    .rstN   (rstN),
    .ctrl   (ctrl),
    .state  (state),
    .retire (retire)
);

//--- sim/cpuChecker.sv
`timescale 1ns/10ps

module cpuChecker import mipsPkg::*; #(
    parameter int unsigned memWords = 256,
    parameter logic [31:0] resetPc  = 32'h0
) (
    input logic        clk,
    input logic        rstN,
    input logic        loadEn,
    input logic [31:0] loadAddr,
    input logic [31:0] loadData,
    input retireS      retire
);

    localparam int idxBits = $clog2(memWords);

    logic [31:0] modelMem [memWords];
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic        halted;
    int          cycles;
    int          retireCount;
    int          errorCount = 0;
    string       testName = "none";

    // same wrap as the memory array
    function automatic logic [idxBits-1:0] wordIndex(logic [31:0] addr);
        return idxBits'((addr >> 2) % memWords);
    endfunction

    task automatic compareField(string field, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED %s %s at pc %h: expected %h, actual %h",
                     testName, field, modelPc, expected, actual);
        end
    endtask

    // one instruction of the ISA model against one retire report
    task automatic stepModel();
        logic [31:0] instr;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] sImm;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] value;
        logic [5:0]  op;
        logic [4:0]  dest;
        logic        wr;
        logic        mw;
        int          expCycles;
        instr  = modelMem[wordIndex(modelPc)];
        op     = instr[31:26];
        rsVal  = modelRegs[instr[25:21]];
        rtVal  = modelRegs[instr[20:16]];
        sImm   = {{16{instr[15]}}, instr[15:0]};
        nextPc = modelPc + 32'd4;
        addr   = '0;
        value  = '0;
        dest   = instr[20:16];
        wr     = 1'b0;
        mw     = 1'b0;
        expCycles = 3;
        case (op)
            opR: begin
                wr = 1'b1;
                dest = instr[15:11];
                expCycles = 4;
                case (instr[5:0])
                    fnAdd:   value = rsVal + rtVal;
                    fnSub:   value = rsVal - rtVal;
                    fnAnd:   value = rsVal & rtVal;
                    fnOr:    value = rsVal | rtVal;
                    fnSlt:   value = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
                    default: begin
                        wr = 1'b0;
                        expCycles = 3;
                    end
                endcase
            end
            opAddi: begin
                wr = 1'b1;
                value = rsVal + sImm;
                expCycles = 4;
            end
            opOri: begin
                wr = 1'b1;
                value = rsVal | {16'h0, instr[15:0]};
                expCycles = 4;
            end
            opLui: begin
                wr = 1'b1;
                value = {instr[15:0], 16'h0};
                expCycles = 4;
            end
            opLw: begin
                wr = 1'b1;
                addr = rsVal + sImm;
                value = modelMem[wordIndex(addr)];
                expCycles = 5;
            end
            opSw: begin
                mw = 1'b1;
                addr = rsVal + sImm;
                expCycles = 4;
            end
            opBeq: begin
                if (rsVal == rtVal) begin
                    nextPc = modelPc + 32'd4 + (sImm << 2);
                end
            end
            opBne: begin
                if (rsVal != rtVal) begin
                    nextPc = modelPc + 32'd4 + (sImm << 2);
                end
            end
            opJ: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
            opJal: begin
                wr = 1'b1;
                dest = 5'd31;
                value = modelPc + 32'd4;
                nextPc = {nextPc[31:28], instr[25:0], 2'b00};
            end
            default: ;
        endcase

        compareField("pc", modelPc, retire.pc);
        compareField("cycles", expCycles, cycles);
        compareField("regWrite", {31'b0, wr}, {31'b0, retire.regWrite});
        compareField("memWrite", {31'b0, mw}, {31'b0, retire.memWrite});
        if (wr) begin
            compareField("regNum", {27'b0, dest}, {27'b0, retire.regNum});
            compareField("regData", value, retire.regData);
        end
        if (mw) begin
            compareField("memAddr", 32'(wordIndex(addr)) << 2, retire.memAddr);
            compareField("memData", rtVal, retire.memData);
        end

        // register 0 keeps its zero
        if (wr && (dest != 5'd0)) begin
            modelRegs[dest] = value;
        end
        if (mw) begin
            modelMem[wordIndex(addr)] = rtVal;
        end
        if (nextPc == modelPc) begin
            halted = 1'b1;
        end
        modelPc = nextPc;
        retireCount++;
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            if (loadEn) begin
                modelMem[wordIndex(loadAddr)] = loadData;
            end
            modelPc = resetPc;
            cycles = 0;
            retireCount = 0;
            halted = 1'b0;
            // only register 0 has a known value
            for (int r = 0; r < 32; r++) begin
                modelRegs[5'(r)] = (r == 0) ? 32'h0 : 'x;
            end
        end else begin
            cycles++;
            if (retire.valid) begin
                stepModel();
                cycles = 0;
            end
        end
    end

endmodule

//--- sim/cpuTb.sv
`timescale 1ns/10ps

module cpuTb import mipsPkg::*; ();

    localparam int unsigned memWords = 256;
    localparam logic [31:0] resetPc  = 32'h0;
    localparam int idxBits       = $clog2(memWords);
    localparam int resetCycles   = 16;
    localparam int loadCycles    = (int'(memWords) > resetCycles) ? int'(memWords) : resetCycles;
    localparam int timeoutCycles = 2000;
    localparam int prologueLen   = 31;
    localparam int bodyLen       = 40;
    localparam int haltIdx       = prologueLen + bodyLen;

    localparam int kindAlu   = 0;
    localparam int kindImm   = 1;
    localparam int kindMem   = 2;
    localparam int kindCtrl  = 3;
    localparam int kindMixed = 4;

    logic        clk;
    logic        rstN;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    retireS      retire;

    logic [31:0] lcgState;
    logic [31:0] prog [memWords];
    int          passCount;
    int          failCount;

    cpuTop #(
        .memWords (memWords),
        .resetPc  (resetPc)
    ) dut (
        .clk      (clk),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .retire   (retire)
    );

    cpuChecker #(
        .memWords (memWords),
        .resetPc  (resetPc)
    ) chk (
        .clk      (clk),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // halves swapped since the low LCG bits have short periods
    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'(32'd1 + lcgNext() % 32'd7);
    endfunction

    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          functE fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(opcodeE op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(opcodeE op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic logic [31:0] randomInstr(int kind, int wordIdx);
        int          cls;
        int          pick;
        int          off;
        int          room;
        int          window;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] memOff;
        functE       fn;
        // targets stay forward and end at the final jump
        room = haltIdx - wordIdx - 1;
        off = int'(lcgNext() % 32'd4);
        if (off > room) begin
            off = room;
        end
        // the R-type run also reads and writes r0
        rs = (kind == kindAlu) ? 5'(lcgNext() % 32'd8) : pickReg();
        rt = pickReg();
        rd = (kind == kindAlu) ? 5'(lcgNext() % 32'd8) : pickReg();
        imm = 16'(lcgNext());
        window = (kind == kindMem) ? 8 : 128;
        memOff = 16'(32'd512 + 32'd4 * (lcgNext() % 32'(window)));
        pick = int'(lcgNext() % 32'd10);
        case (lcgNext() % 32'd5)
            32'd0:   fn = fnAdd;
            32'd1:   fn = fnSub;
            32'd2:   fn = fnAnd;
            32'd3:   fn = fnOr;
            default: fn = fnSlt;
        endcase
        case (kind)
            kindAlu:  cls = (wordIdx < prologueLen + 7) ? 1 : 0;
            kindImm:  cls = 1 + pick % 3;
            kindMem:  cls = (pick < 3) ? 1 : ((pick < 6) ? 5 : 4);
            kindCtrl: cls = (pick < 4) ? 1 : ((pick < 6) ? 6 : ((pick < 8) ? 7 : pick));
            default:  cls = pick;
        endcase
        // seed r1..r7 before the R-type run
        if (kind == kindAlu && cls == 1) begin
            rs = 5'd0;
            rt = 5'(wordIdx - prologueLen + 1);
        end
        // few distinct values so branches go both ways
        if (kind == kindCtrl && cls == 1) begin
            rs = 5'd0;
            imm = 16'(lcgNext() % 32'd3);
        end
        case (cls)
            0:       return rType(rs, rt, rd, fn);
            1:       return iType(opAddi, rs, rt, imm);
            2:       return iType(opOri, rs, rt, imm);
            3:       return iType(opLui, 5'd0, rt, imm);
            4:       return iType(opLw, 5'd0, rt, memOff);
            5:       return iType(opSw, 5'd0, rt, memOff);
            6:       return iType(opBeq, rs, rt, 16'(off));
            7:       return iType(opBne, rs, rt, 16'(off));
            8:       return jType(opJ, 26'(wordIdx + 1 + off));
            default: return jType(opJal, 26'(wordIdx + 1 + off));
        endcase
    endfunction

    // prologue clearing r1..r31 followed by body, jump to self and fill
    task automatic buildProgram(int kind);
        for (int w = 0; w < int'(memWords); w++) begin
            if (w < prologueLen) begin
                prog[idxBits'(w)] = iType(opOri, 5'd0, 5'(w + 1), 16'h0);
            end else if (w < haltIdx) begin
                prog[idxBits'(w)] = randomInstr(kind, w);
            end else if (w == haltIdx) begin
                prog[idxBits'(w)] = jType(opJ, 26'(haltIdx));
            end else begin
                prog[idxBits'(w)] = 32'h5a5a_0000 ^ (32'(w) * 32'h9e37_79b9);
            end
        end
    endtask

    task automatic runTest(string name, int kind);
        int startErrors;
        int startAsserts;
        int waited;
        startAsserts = dut.cpu.stateChecks.failures;
        @(posedge clk);
        #1;
        rstN = 1'b0;
        chk.testName = name;
        buildProgram(kind);
        // reset stays low for the whole preload
        for (int cyc = 0; cyc < loadCycles; cyc++) begin
            loadEn = (cyc < int'(memWords));
            loadAddr = 32'(cyc) << 2;
            loadData = prog[idxBits'(cyc)];
            @(posedge clk);
            #1;
        end
        loadEn = 1'b0;
        rstN = 1'b1;
        startErrors = chk.errorCount;
        waited = 0;
        while (!chk.halted && waited < timeoutCycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!chk.halted) begin
            $display("timeout: %s did not reach its final jump within %0d cycles",
                     name, timeoutCycles);
            failCount++;
        end else if (chk.errorCount != startErrors ||
                     dut.cpu.stateChecks.failures != startAsserts) begin
            $display("%s: fail, %0d mismatches, %0d assertion failures, %0d retirements",
                     name, chk.errorCount - startErrors,
                     dut.cpu.stateChecks.failures - startAsserts, chk.retireCount);
            failCount++;
        end else begin
            $display("%s: pass, %0d retirements", name, chk.retireCount);
            passCount++;
        end
    endtask

    initial begin
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lcgState = 32'hf133_9b18;
        passCount = 0;
        failCount = 0;
        runTest("alu", kindAlu);
        runTest("immediate", kindImm);
        runTest("memory", kindMem);
        runTest("control", kindCtrl);
        runTest("mixed0", kindMixed);
        runTest("mixed1", kindMixed);
        runTest("mixed2", kindMixed);
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
logic/mipsPkg.sv
logic/alu.sv
logic/regFile.sv
logic/unifiedMemory.sv
logic/multiCycleControl.sv
logic/multiCycleCpu.sv
logic/cpuTop.sv
sim/cpu_assertions.sv
sim/cpuChecker.sv
sim/cpuTb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module cpuTb -f list.f

run: build
	./obj_dir/VcpuTb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module cpuTb -f list.f

clean:
	rm -rf obj_dir sim.log
